//--- rtl/chiplet_pkg.sv
package chiplet_pkg;

    localparam int NUM_TILES    = 4;
    localparam int NUM_LINKS    = 2;
    localparam int TILE_BITS    = 2;
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int PAYLOAD_BITS = 16;
    localparam int PKT_BITS     = 2 * TILE_BITS + PAYLOAD_BITS;
    localparam int BUFFER_SIZE  = 8;
    localparam int BIT_CYCLES   = 4;

    // Derived widths.
    localparam int PTR_BITS     = $clog2(BUFFER_SIZE);
    localparam int COUNT_BITS   = PTR_BITS + 1;
    localparam int BIT_CNT_BITS = $clog2(BIT_CYCLES);
    localparam int IDX_BITS     = $clog2(PKT_BITS);
    localparam int DROP_BITS    = 8;

    typedef struct packed {
        logic [TILE_BITS-1:0]    dest;
        logic [TILE_BITS-1:0]    src;
        logic [PAYLOAD_BITS-1:0] payload;
    } pkt_t;

    typedef struct packed {
        logic                    wen;
        logic                    ren;
        logic [ADDR_WIDTH-1:0]   addr;
        logic [DATA_WIDTH-1:0]   wdata;
        logic [DATA_WIDTH/8-1:0] strobe;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] rdata;
        logic                  error;
        logic                  request_stall;
    } bus_rsp_t;

    typedef enum logic [ADDR_WIDTH-1:0] {
        REG_SEND   = 32'h0,
        REG_RECV   = 32'h4,
        REG_STATUS = 32'h8
    } reg_addr_e;

    // Shared by transmitter and receiver.
    typedef enum logic [1:0] {
        LINK_IDLE,
        LINK_START,
        LINK_DATA,
        LINK_STOP
    } link_state_e;

    // Values double as source index.
    typedef enum logic [1:0] {
        SRC_LINK0 = 2'd0,
        SRC_LINK1 = 2'd1,
        SRC_LOCAL = 2'd2,
        SRC_NONE  = 2'd3
    } src_sel_e;

endpackage

//--- rtl/pkt_fifo.sv
`timescale 1ns/1ns

module pkt_fifo (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                push,
    input  chiplet_pkg::pkt_t                   push_pkt,
    input  logic                                pop,
    output chiplet_pkg::pkt_t                   head,
    output logic                                empty,
    output logic                                full,
    output logic [chiplet_pkg::COUNT_BITS-1:0]  count
);
    import chiplet_pkg::*;

    pkt_t                mem [BUFFER_SIZE];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Pointers wrap.
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == COUNT_BITS'(BUFFER_SIZE));

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(push && full))
        else $error("pkt_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
        else $error("pkt_fifo: pop while empty");

endmodule

//--- rtl/uart_tx_link.sv
`timescale 1ns/1ns

module uart_tx_link (
    input  logic              clk,
    input  logic              rst,
    input  logic              load,
    input  chiplet_pkg::pkt_t pkt,
    output logic              busy,
    output logic              tx
);
    import chiplet_pkg::*;

    link_state_e             state;
    pkt_t                    frame;
    logic [BIT_CNT_BITS-1:0] cnt;
    logic [IDX_BITS-1:0]     idx;
    logic                    bit_end;

    assign bit_end = (cnt == BIT_CNT_BITS'(BIT_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LINK_IDLE;
            cnt   <= '0;
            idx   <= '0;
        end else begin
            if (state == LINK_IDLE) cnt <= '0;
            else cnt <= bit_end ? '0 : cnt + 1'b1;

            case (state)
                LINK_IDLE: begin
                    if (load) state <= LINK_START;
                end
                LINK_START: begin
                    if (bit_end) begin
                        state <= LINK_DATA;
                        idx   <= '0;
                    end
                end
                LINK_DATA: begin
                    if (bit_end) begin
                        if (idx == IDX_BITS'(PKT_BITS - 1)) state <= LINK_STOP;
                        else idx <= idx + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) state <= LINK_IDLE;  // End of stop bit.
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load && state == LINK_IDLE) frame <= pkt;
    end

    always_comb begin
        case (state)
            LINK_START: tx = 1'b0;
            LINK_DATA:  tx = frame[idx];  // LSB first.
            default:    tx = 1'b1;
        endcase
    end

    assign busy = (state != LINK_IDLE);

    a_load_idle: assert property (@(posedge clk) disable iff (rst) load |-> !busy)
        else $error("uart_tx_link: load while busy");

endmodule

//--- rtl/uart_rx_link.sv
`timescale 1ns/1ns

module uart_rx_link (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx,
    output logic              valid,
    output chiplet_pkg::pkt_t pkt
);
    import chiplet_pkg::*;

    link_state_e             state;
    pkt_t                    shreg;
    logic [BIT_CNT_BITS-1:0] cnt;
    logic [IDX_BITS-1:0]     idx;
    logic                    mid;
    logic                    bit_end;

    // Middle of a bit.
    assign mid     = (cnt == BIT_CNT_BITS'(BIT_CYCLES / 2 - 1));
    assign bit_end = (cnt == BIT_CNT_BITS'(BIT_CYCLES - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LINK_IDLE;
            cnt   <= '0;
            idx   <= '0;
        end else begin
            // The detecting cycle is already the first cycle of the start bit.
            if (state == LINK_IDLE) cnt <= BIT_CNT_BITS'(1);
            else cnt <= bit_end ? '0 : cnt + 1'b1;

            case (state)
                LINK_IDLE: begin
                    if (!rx) state <= LINK_START;  // Falling edge.
                end
                LINK_START: begin
                    if (mid && rx) begin
                        state <= LINK_IDLE;  // Glitch, not a start bit.
                    end else if (bit_end) begin
                        state <= LINK_DATA;
                        idx   <= '0;
                    end
                end
                LINK_DATA: begin
                    if (bit_end) begin
                        if (idx == IDX_BITS'(PKT_BITS - 1)) state <= LINK_STOP;
                        else idx <= idx + 1'b1;
                    end
                end
                default: begin
                    if (mid) state <= LINK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LINK_DATA && mid) begin
            shreg <= {rx, shreg[PKT_BITS-1:1]};
        end
    end

    // Frames with a low stop bit are discarded.
    assign valid = (state == LINK_STOP) && mid && rx;
    assign pkt   = shreg;

endmodule

//--- rtl/tile_ctrl.sv
`timescale 1ns/1ns

module tile_ctrl #(
    parameter int TILE_ID = 0
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  chiplet_pkg::bus_req_t                req,
    output chiplet_pkg::bus_rsp_t                rsp,
    input  chiplet_pkg::pkt_t                    link_head [chiplet_pkg::NUM_LINKS],
    input  logic [chiplet_pkg::NUM_LINKS-1:0]    link_empty,
    output logic [chiplet_pkg::NUM_LINKS-1:0]    link_pop,
    input  logic [chiplet_pkg::NUM_LINKS-1:0]    link_frame_valid,
    input  logic [chiplet_pkg::NUM_LINKS-1:0]    link_full,
    input  chiplet_pkg::pkt_t                    inj_head,
    input  logic                                 inj_empty,
    input  logic                                 inj_full,
    output logic                                 inj_push,
    output chiplet_pkg::pkt_t                    inj_pkt,
    output logic                                 inj_pop,
    input  chiplet_pkg::pkt_t                    dlv_head,
    input  logic                                 dlv_empty,
    input  logic                                 dlv_full,
    input  logic [chiplet_pkg::COUNT_BITS-1:0]   dlv_count,
    output logic                                 dlv_push,
    output chiplet_pkg::pkt_t                    dlv_pkt,
    output logic                                 dlv_pop,
    input  logic [chiplet_pkg::NUM_LINKS-1:0]    tx_busy,
    output logic [chiplet_pkg::NUM_LINKS-1:0]    tx_load,
    output chiplet_pkg::pkt_t                    tx_pkt [chiplet_pkg::NUM_LINKS]
);
    import chiplet_pkg::*;

    logic [TILE_BITS-1:0]            my_id;
    logic [DROP_BITS-1:0]            drop_cnt;
    logic [DROP_BITS:0]              drop_sum;
    pkt_t                            src_head [NUM_LINKS+1];
    logic [NUM_LINKS:0]              src_valid;
    logic [NUM_LINKS:0]              tgt_ready;
    logic [1:0]                      src_tgt [NUM_LINKS+1];
    src_sel_e                        sel [NUM_LINKS+1];
    logic [NUM_LINKS:0][NUM_LINKS:0] grant;  // grant[source][target].

    assign my_id = TILE_BITS'(TILE_ID);

    always_comb begin : bus_decode
        rsp      = '0;
        inj_push = 1'b0;
        dlv_pop  = 1'b0;
        inj_pkt.dest    = req.wdata[PAYLOAD_BITS +: TILE_BITS];
        inj_pkt.src     = my_id;
        inj_pkt.payload = req.wdata[PAYLOAD_BITS-1:0];
        if (req.wen) begin
            case (req.addr)
                REG_SEND: begin
                    if (req.strobe != '1) rsp.error = 1'b1;
                    else if (inj_full) rsp.request_stall = 1'b1;
                    else inj_push = 1'b1;
                end
                default: rsp.error = 1'b1;  // Read-only or unmapped.
            endcase
        end else if (req.ren) begin
            case (req.addr)
                REG_RECV: begin
                    if (!dlv_empty) begin
                        rsp.rdata[DATA_WIDTH-1]               = 1'b1;
                        rsp.rdata[PAYLOAD_BITS +: TILE_BITS]  = dlv_head.src;
                        rsp.rdata[PAYLOAD_BITS-1:0]           = dlv_head.payload;
                        dlv_pop                               = 1'b1;
                    end
                end
                REG_STATUS: begin
                    rsp.rdata[COUNT_BITS-1:0]  = dlv_count;
                    rsp.rdata[8]               = inj_full;
                    rsp.rdata[16 +: DROP_BITS] = drop_cnt;
                end
                default: rsp.error = 1'b1;
            endcase
        end
    end

    always_comb begin : route_arb
        for (int l = 0; l < NUM_LINKS; l++) begin
            src_head[l]  = link_head[l];
            src_valid[l] = !link_empty[l];
            tgt_ready[l] = !tx_busy[l];
        end
        src_head[NUM_LINKS]  = inj_head;
        src_valid[NUM_LINKS] = !inj_empty;
        tgt_ready[NUM_LINKS] = !dlv_full;

        // Dimension order: fix bit 0 first, then bit 1.
        for (int s = 0; s <= NUM_LINKS; s++) begin
            if (src_head[s].dest == my_id) src_tgt[s] = 2'(NUM_LINKS);
            else if (src_head[s].dest[0] != my_id[0]) src_tgt[s] = {1'b0, my_id[1]};
            else src_tgt[s] = {1'b0, ~my_id[1]};
        end

        grant = '0;
        for (int t = 0; t <= NUM_LINKS; t++) begin
            sel[t] = SRC_NONE;
            for (int s = 0; s <= NUM_LINKS; s++) begin
                if (sel[t] == SRC_NONE && tgt_ready[t] && src_valid[s]
                        && src_tgt[s] == 2'(t)) begin
                    sel[t]      = src_sel_e'(2'(s));
                    grant[s][t] = 1'b1;
                end
            end
        end
    end

    always_comb begin : drive_targets
        for (int t = 0; t < NUM_LINKS; t++) begin
            tx_load[t] = (sel[t] != SRC_NONE);
            tx_pkt[t]  = src_head[0];
            for (int s = 0; s <= NUM_LINKS; s++) begin
                if (grant[s][t]) tx_pkt[t] = src_head[s];
            end
            link_pop[t] = |grant[t];
        end
        dlv_push = (sel[NUM_LINKS] != SRC_NONE);
        dlv_pkt  = src_head[0];
        for (int s = 0; s <= NUM_LINKS; s++) begin
            if (grant[s][NUM_LINKS]) dlv_pkt = src_head[s];
        end
        inj_pop = |grant[NUM_LINKS];
    end

    always_comb begin
        drop_sum = {1'b0, drop_cnt};
        for (int l = 0; l < NUM_LINKS; l++) begin
            if (link_frame_valid[l] && link_full[l]) drop_sum = drop_sum + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) drop_cnt <= '0;
        else drop_cnt <= drop_sum[DROP_BITS] ? '1 : drop_sum[DROP_BITS-1:0];  // Saturates.
    end

    // One pop for every packet a target takes.
    a_pop_per_load: assert property (@(posedge clk) disable iff (rst)
        $countones({link_pop, inj_pop}) == $countones({tx_load, dlv_push}))
        else $error("tile_ctrl: FIFO pops do not match accepted packets");

endmodule

//--- rtl/tile.sv
`timescale 1ns/1ns

module tile #(
    parameter int TILE_ID = 0
) (
    input  logic                              clk,
    input  logic                              rst,
    input  chiplet_pkg::bus_req_t             req,
    output chiplet_pkg::bus_rsp_t             rsp,
    input  logic [chiplet_pkg::NUM_LINKS-1:0] rx,
    output logic [chiplet_pkg::NUM_LINKS-1:0] tx
);
    import chiplet_pkg::*;

    pkt_t                  link_head [NUM_LINKS];
    pkt_t                  rx_pkt [NUM_LINKS];
    pkt_t                  tx_pkt [NUM_LINKS];
    logic [NUM_LINKS-1:0]  link_empty;
    logic [NUM_LINKS-1:0]  link_full;
    logic [NUM_LINKS-1:0]  link_push;
    logic [NUM_LINKS-1:0]  link_pop;
    logic [NUM_LINKS-1:0]  frame_valid;
    logic [NUM_LINKS-1:0]  tx_busy;
    logic [NUM_LINKS-1:0]  tx_load;
    pkt_t                  inj_head;
    pkt_t                  inj_pkt;
    logic                  inj_empty;
    logic                  inj_full;
    logic                  inj_push;
    logic                  inj_pop;
    pkt_t                  dlv_head;
    pkt_t                  dlv_pkt;
    logic                  dlv_empty;
    logic                  dlv_full;
    logic                  dlv_push;
    logic                  dlv_pop;
    logic [COUNT_BITS-1:0] dlv_count;

    for (genvar l = 0; l < NUM_LINKS; l++) begin : g_link
        uart_rx_link u_rx (
            .clk(clk), .rst(rst), .rx(rx[l]), .valid(frame_valid[l]), .pkt(rx_pkt[l])
        );

        // A frame meeting a full FIFO is lost.
        assign link_push[l] = frame_valid[l] && !link_full[l];

        pkt_fifo u_link_fifo (
            .clk(clk), .rst(rst),
            .push(link_push[l]), .push_pkt(rx_pkt[l]), .pop(link_pop[l]),
            .head(link_head[l]), .empty(link_empty[l]), .full(link_full[l]), .count()
        );

        uart_tx_link u_tx (
            .clk(clk), .rst(rst), .load(tx_load[l]), .pkt(tx_pkt[l]),
            .busy(tx_busy[l]), .tx(tx[l])
        );
    end

    pkt_fifo u_inj_fifo (
        .clk(clk), .rst(rst), .push(inj_push), .push_pkt(inj_pkt), .pop(inj_pop),
        .head(inj_head), .empty(inj_empty), .full(inj_full), .count()
    );

    pkt_fifo u_dlv_fifo (
        .clk(clk), .rst(rst), .push(dlv_push), .push_pkt(dlv_pkt), .pop(dlv_pop),
        .head(dlv_head), .empty(dlv_empty), .full(dlv_full), .count(dlv_count)
    );

    tile_ctrl #(.TILE_ID(TILE_ID)) u_ctrl (
        .clk(clk), .rst(rst), .req(req), .rsp(rsp),
        .link_head(link_head), .link_empty(link_empty), .link_pop(link_pop),
        .link_frame_valid(frame_valid), .link_full(link_full),
        .inj_head(inj_head), .inj_empty(inj_empty), .inj_full(inj_full),
        .inj_push(inj_push), .inj_pkt(inj_pkt), .inj_pop(inj_pop),
        .dlv_head(dlv_head), .dlv_empty(dlv_empty), .dlv_full(dlv_full),
        .dlv_count(dlv_count), .dlv_push(dlv_push), .dlv_pkt(dlv_pkt), .dlv_pop(dlv_pop),
        .tx_busy(tx_busy), .tx_load(tx_load), .tx_pkt(tx_pkt)
    );

endmodule

//--- rtl/tile_wrapper.sv
`timescale 1ns/1ns

module tile_wrapper (
    input  logic                  clk,
    input  logic                  rst,
    input  chiplet_pkg::bus_req_t req [chiplet_pkg::NUM_TILES],
    output chiplet_pkg::bus_rsp_t rsp [chiplet_pkg::NUM_TILES]
);
    import chiplet_pkg::*;

    logic [NUM_LINKS-1:0] link_rx [NUM_TILES];
    logic [NUM_LINKS-1:0] link_tx [NUM_TILES];

    for (genvar t = 0; t < NUM_TILES; t++) begin : g_tile
        tile #(
            .TILE_ID(t)
        ) tile_i (
            .clk(clk),
            .rst(rst),
            .req(req[t]),
            .rsp(rsp[t]),
            .rx(link_rx[t]),
            .tx(link_tx[t])
        );
    end

    // Tiles 0 and 1, then 0 and 2.
    assign link_rx[0][0] = link_tx[1][0];
    assign link_rx[0][1] = link_tx[2][0];

    assign link_rx[1][0] = link_tx[0][0];
    assign link_rx[1][1] = link_tx[3][0];

    assign link_rx[2][0] = link_tx[0][1];
    assign link_rx[2][1] = link_tx[3][1];

    assign link_rx[3][0] = link_tx[1][1];  // Tiles 1 and 3, then 2 and 3.
    assign link_rx[3][1] = link_tx[2][1];

endmodule

//--- tests/tile_wrapper_tb.sv
`timescale 1ns/1ns

module tile_wrapper_tb;
    import chiplet_pkg::*;

    localparam int NUM_PKTS     = 30;
    localparam int FRAME_CYCLES = 88;
    localparam int MIN_HOP      = 84;  // Fastest start edge to valid pulse.
    localparam int TIMEOUT      = NUM_PKTS * 3 * FRAME_CYCLES + 2000;

    logic        clk;
    logic        rst;
    bus_req_t    req [NUM_TILES];
    bus_rsp_t    rsp [NUM_TILES];
    bus_req_t    host_req [NUM_TILES];
    bus_req_t    poll_req [NUM_TILES];
    logic        poll_en;
    logic        strict;
    logic        stall_seen;
    int          cycle;
    int          val_errs;
    int          other_errs;
    logic [47:0] exp_q [NUM_TILES*NUM_TILES][$];  // {send cycle, payload}.

    tile_wrapper DUT (.clk(clk), .rst(rst), .req(req), .rsp(rsp));

    // Host accesses win over the background poll.
    for (genvar t = 0; t < NUM_TILES; t++) begin : g_mux
        assign req[t] = (host_req[t].wen || host_req[t].ren) ? host_req[t] : poll_req[t];
    end

    always #50 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    function automatic bus_req_t make_req(input logic wen, input logic ren,
                                          input logic [31:0] addr, input logic [31:0] wdata,
                                          input logic [3:0] strobe);
        return '{wen: wen, ren: ren, addr: addr, wdata: wdata, strobe: strobe};
    endfunction

    // Dimension order over the wired neighbour table.
    function automatic int next_tile(input int cur, input int dest);
        int nbr [4][2];
        int link;
        nbr = '{'{1, 2}, '{0, 3}, '{0, 3}, '{1, 2}};
        if (cur == dest) return cur;
        link = ((dest & 1) != (cur & 1)) ? ((cur >> 1) & 1) : (~(cur >> 1) & 1);
        return nbr[cur][link];
    endfunction

    function automatic int hop_count(input int src, input int dest);
        int cur;
        int hops;
        cur  = src;
        hops = 0;
        while (cur != dest && hops < NUM_TILES) begin
            cur = next_tile(cur, dest);
            hops++;
        end
        return hops;
    endfunction

    function automatic logic [31:0] expected_recv(input int src, input logic [15:0] payload);
        return {1'b1, 13'd0, 2'(src), payload};
    endfunction

    task automatic check_packet(input int t, input logic [31:0] rdata);
        int          src;
        int          hops;
        int          lat;
        logic [47:0] entry;
        src = int'(rdata[17:16]);
        if (exp_q[src*NUM_TILES+t].size() == 0) begin
            $display("Tile %0d got an unexpected packet from tile %0d at %0t.", t, src, $time);
            other_errs++;
        end else begin
            entry = exp_q[src*NUM_TILES+t].pop_front();
            if (rdata != expected_recv(src, entry[15:0])) begin
                $display("error at %0t: rsp[%0d].rdata expected %h got %h", $time, t,
                         expected_recv(src, entry[15:0]), rdata);
                val_errs++;
            end
            hops = hop_count(src, t);
            lat  = cycle - int'(entry[47:16]);
            if (lat < hops * MIN_HOP || (strict && lat >= (hops + 1) * MIN_HOP)) begin
                $display("Packet from %0d to %0d took %0d cycles, which does not fit %0d hops.",
                         src, t, lat, hops);
                other_errs++;
            end
        end
    endtask

    always @(posedge clk) begin
        for (int t = 0; t < NUM_TILES; t++) begin
            if (req[t].ren && req[t].addr == REG_RECV && rsp[t].rdata[31]) begin
                check_packet(t, rsp[t].rdata);
            end
            poll_req[t] <= make_req(1'b0, poll_en, REG_RECV, '0, '0);
        end
    end

    task automatic send(input int t, input int dest, input logic [15:0] payload);
        host_req[t] <= make_req(1'b1, 1'b0, REG_SEND, {14'd0, 2'(dest), payload}, '1);
        @(posedge clk);
        while (rsp[t].request_stall) begin
            stall_seen <= 1'b1;
            @(posedge clk);
        end
        if (rsp[t].error) begin
            $display("error at %0t: rsp[%0d].error expected 0 got 1", $time, t);
            val_errs++;
        end
        exp_q[t*NUM_TILES+dest].push_back({32'(cycle), payload});
        host_req[t] <= '0;
    endtask

    task automatic access(input int t, input logic wen, input logic [31:0] addr,
                          input logic [3:0] strobe, output bus_rsp_t r);
        host_req[t] <= make_req(wen, !wen, addr, 32'h0001_1234, strobe);  // Dest 1.
        @(posedge clk);
        r = rsp[t];
        host_req[t] <= '0;
    endtask

    task automatic check_error(input int t, input logic wen, input logic [31:0] addr,
                               input logic [3:0] strobe);
        bus_rsp_t r;
        access(t, wen, addr, strobe, r);
        if (!r.error) begin
            $display("error at %0t: rsp[%0d].error expected 1 got 0", $time, t);
            val_errs++;
        end
    endtask

    task automatic check_status(input int t, input logic [31:0] mask);
        bus_rsp_t r;
        access(t, 1'b0, REG_STATUS, '0, r);
        if ((r.rdata & mask) != 32'h0) begin
            $display("error at %0t: rsp[%0d].rdata expected %h got %h", $time, t,
                     32'h0, r.rdata & mask);
            val_errs++;
        end
        if (r.error || r.request_stall) begin
            $display("Tile %0d raised error or request_stall on a status read.", t);
            other_errs++;
        end
    endtask

    task automatic wait_drain();
        int pending;
        do begin
            @(posedge clk);
            pending = 0;
            for (int i = 0; i < NUM_TILES * NUM_TILES; i++) pending += exp_q[i].size();
        end while (pending != 0);
    endtask

    task automatic end_run();
        $display("Closing: %0d value errors, %0d other failures", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    initial begin
        wait (cycle >= TIMEOUT);
        $display("Timeout after %0d cycles with traffic still outstanding.", TIMEOUT);
        other_errs++;
        end_run();
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        poll_en    = 1'b0;
        strict     = 1'b0;
        stall_seen = 1'b0;
        cycle      = 0;
        val_errs   = 0;
        other_errs = 0;
        for (int t = 0; t < NUM_TILES; t++) begin
            host_req[t] = '0;
            poll_req[t] = '0;
        end
        void'($urandom(32'he945));
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        for (int t = 0; t < NUM_TILES; t++) check_status(t, '1);
        poll_en <= 1'b1;

        strict <= 1'b1;  // One link per neighbour send.
        for (int s = 0; s < NUM_TILES; s++) begin
            for (int d = 0; d < NUM_TILES; d++) begin
                if (hop_count(s, d) == 1) send(s, d, 16'($urandom));
            end
        end
        wait_drain();
        strict <= 1'b0;

        repeat (2) begin
            send(0, 3, 16'($urandom));
            send(3, 0, 16'($urandom));
            send(1, 2, 16'($urandom));
            send(2, 1, 16'($urandom));
        end
        wait_drain();

        // Self sends stay off the links.
        strict <= 1'b1;
        for (int t = 0; t < NUM_TILES; t++) send(t, t, 16'($urandom));
        wait_drain();
        strict <= 1'b0;

        check_error(0, 1'b1, 32'h10, '1);
        check_error(1, 1'b1, REG_SEND, 4'b0111);
        check_error(2, 1'b1, REG_RECV, '1);
        check_error(3, 1'b0, REG_SEND, '0);
        repeat (4 * FRAME_CYCLES) @(posedge clk);  // Room for a stray two hop frame.

        for (int i = 0; i < 10; i++) send(0, 1, 16'($urandom));
        if (!stall_seen) begin
            $display("request_stall never rose during the back-to-back sends.");
            other_errs++;
        end
        wait_drain();
        for (int t = 0; t < NUM_TILES; t++) check_status(t, 32'h00FF_000F);
        end_run();
    end

endmodule

//--- verilog.f
rtl/chiplet_pkg.sv
rtl/pkt_fifo.sv
rtl/uart_tx_link.sv
rtl/uart_rx_link.sv
rtl/tile_ctrl.sv
rtl/tile.sv
rtl/tile_wrapper.sv
tests/tile_wrapper_tb.sv

//--- Makefile
TOP = tile_wrapper_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		-f verilog.f --top-module $(TOP) -Mdir build -o sim
	./build/sim | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf build sim.log
